// ==== logic/coreTypesPkg.sv ====
/*
 * Core type package for the complex integer slice
 * Widths, register and active-list pointer types, multiply opcodes
 */
package coreTypesPkg;

    localparam int DATA_WIDTH = 32;
    localparam int PHY_REG_NUM = 64;
    localparam int ACTIVE_LIST_ENTRY_NUM = 16;

    // Derived index widths
    localparam int PHY_REG_NUM_WIDTH = $clog2(PHY_REG_NUM);
    localparam int ACTIVE_LIST_INDEX_WIDTH = $clog2(ACTIVE_LIST_ENTRY_NUM);

    typedef logic [DATA_WIDTH-1:0] DataPath;
    typedef logic [2*DATA_WIDTH-1:0] ProductPath;
    typedef logic [PHY_REG_NUM_WIDTH-1:0] PRegNumPath;
    typedef logic [ACTIVE_LIST_INDEX_WIDTH-1:0] ActiveListIndexPath;

    // Which half of the product goes to the destination
    typedef enum logic [1:0] {
        mulLow          = 2'b00,
        mulHighSigned   = 2'b01,
        mulHighUnsigned = 2'b10
    } MulOpCode;

endpackage

// ==== logic/pipeTypesPkg.sv ====
/*
 * Pipeline payload package for the complex integer slice
 * Issue, result and flush-range structs plus the selective flush check
 */
package pipeTypesPkg;

    // Destination info that rides along with an op
    typedef struct packed {
        logic writeReg;
        coreTypesPkg::PRegNumPath phyDstRegNum;
        coreTypesPkg::ActiveListIndexPath activeListPtr;
    } OpTag;

    typedef struct packed {
        logic valid;
        coreTypesPkg::MulOpCode opCode;
        coreTypesPkg::DataPath srcA;
        coreTypesPkg::DataPath srcB;
        OpTag tag;
    } ComplexIssueData;

    typedef struct packed {
        logic valid;
        OpTag tag;
        coreTypesPkg::DataPath dataOut;
    } ComplexResult;

    // Recovery flush window over the active list
    typedef struct packed {
        logic active;
        coreTypesPkg::ActiveListIndexPath headPtr;
        coreTypesPkg::ActiveListIndexPath tailPtr;
        logic flushAll;
    } FlushRange;

    // Half-open [headPtr, tailPtr) with wraparound; head == tail is empty
    function automatic logic inFlushRange(
        input FlushRange flush,
        input coreTypesPkg::ActiveListIndexPath ptr
    );
        coreTypesPkg::ActiveListIndexPath offset;
        coreTypesPkg::ActiveListIndexPath span;
        offset = ptr - flush.headPtr;
        span = flush.tailPtr - flush.headPtr;
        return flush.flushAll || (flush.active && (offset < span));
    endfunction

endpackage

// ==== logic/complexExecStage.sv ====
/*
 * Complex integer execution stage
 * Two-stage multiplier; stage 1 latches operands, stage 2 the product
 */
module complexExecStage (
    input  logic                        ctrl,
    input  logic                        rstN,
    input  logic                        stall,
    input  logic                        clear,
    input  pipeTypesPkg::ComplexIssueData issue,
    output pipeTypesPkg::ComplexResult  result
);

    // Stage 1 state
    logic                      s1Valid;
    coreTypesPkg::MulOpCode    s1OpCode;
    coreTypesPkg::DataPath     s1SrcA;
    coreTypesPkg::DataPath     s1SrcB;
    pipeTypesPkg::OpTag        s1Tag;

    // Stage 2 state
    logic                      s2Valid;
    coreTypesPkg::MulOpCode    s2OpCode;
    coreTypesPkg::ProductPath  s2Product;
    pipeTypesPkg::OpTag        s2Tag;

    // Multiplier operands widened by one bit
    logic                                          signedHigh;
    logic signed [coreTypesPkg::DATA_WIDTH:0]      extA;
    logic signed [coreTypesPkg::DATA_WIDTH:0]      extB;
    logic signed [2*coreTypesPkg::DATA_WIDTH+1:0]  fullProduct;

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else if (!stall) begin
            s1Valid <= issue.valid && !clear;
            s2Valid <= s1Valid && !clear;
        end
    end

    // Payload only moves when the pipe advances
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            s1OpCode <= issue.opCode;
            s1SrcA <= issue.srcA;
            s1SrcB <= issue.srcB;
            s1Tag <= issue.tag;
        end
    end

    // Only the signed-high op needs true sign extension
    assign signedHigh = (s1OpCode == coreTypesPkg::mulHighSigned);
    assign extA = {signedHigh & s1SrcA[coreTypesPkg::DATA_WIDTH-1], s1SrcA};
    assign extB = {signedHigh & s1SrcB[coreTypesPkg::DATA_WIDTH-1], s1SrcB};
    assign fullProduct = extA * extB;

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            s2OpCode <= s1OpCode;
            s2Product <= fullProduct[2*coreTypesPkg::DATA_WIDTH-1:0];
            s2Tag <= s1Tag;
        end
    end

    // Half select feeds the writeback stage
    always_comb begin
        result.valid = s2Valid;
        result.tag = s2Tag;
        if (s2OpCode == coreTypesPkg::mulLow) begin
            result.dataOut = s2Product[coreTypesPkg::DATA_WIDTH-1:0];
        end else begin
            result.dataOut = s2Product[2*coreTypesPkg::DATA_WIDTH-1:coreTypesPkg::DATA_WIDTH];
        end
    end

endmodule

// ==== logic/complexRegWriteStage.sv ====
/*
 * Complex integer register-write stage
 * Latches the multiplier result, filters selective flushes and
 * drives the register file and completion table writes
 */
module complexRegWriteStage (
    input  logic                              ctrl,
    input  logic                              rstN,
    input  logic                              stall,
    input  logic                              clear,
    input  pipeTypesPkg::ComplexResult        result,
    input  pipeTypesPkg::FlushRange           flushRange,
    output logic                              regWe,
    output coreTypesPkg::PRegNumPath          regWriteNum,
    output coreTypesPkg::DataPath             regWriteData,
    output logic                              alWrite,
    output coreTypesPkg::ActiveListIndexPath  alWritePtr,
    output logic                              wbValid,
    output pipeTypesPkg::OpTag                wbTag
);

    // Pipeline register
    logic                   pipeValid;
    pipeTypesPkg::OpTag     pipeTag;
    coreTypesPkg::DataPath  pipeData;

    logic flushed;
    logic update;

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= result.valid && !clear;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            pipeTag <= result.tag;
            pipeData <= result.dataOut;
        end
    end

    // Flush is checked against the range seen in this cycle
    assign flushed = pipeTypesPkg::inFlushRange(flushRange, pipeTag.activeListPtr);
    assign update = !stall && !clear && pipeValid && !flushed;

    // Register file write
    assign regWe = update && pipeTag.writeReg;
    assign regWriteNum = pipeTag.phyDstRegNum;
    assign regWriteData = pipeData;

    // Completion marks even ops without a destination
    assign alWrite = update;
    assign alWritePtr = pipeTag.activeListPtr;

    assign wbValid = update;
    assign wbTag = pipeTag;

endmodule

// ==== logic/physRegFile.sv ====
/*
 * Physical register file
 * One synchronous write port and one asynchronous read port
 */
module physRegFile (
    input  logic                      ctrl,
    input  logic                      rstN,
    input  logic                      we,
    input  coreTypesPkg::PRegNumPath  writeNum,
    input  coreTypesPkg::DataPath     writeData,
    input  coreTypesPkg::PRegNumPath  readNum,
    output coreTypesPkg::DataPath     readData
);

    coreTypesPkg::DataPath regs [coreTypesPkg::PHY_REG_NUM];

    // All registers start at zero
    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < coreTypesPkg::PHY_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[writeNum] <= writeData;
        end
    end

    // Combinational read
    assign readData = regs[readNum];

endmodule

// ==== logic/completionTable.sv ====
/*
 * Active-list completion table
 * One finished bit per entry, cleared on allocate and set on writeback
 */
module completionTable (
    input  logic                              ctrl,
    input  logic                              rstN,
    input  logic                              allocate,
    input  coreTypesPkg::ActiveListIndexPath  allocatePtr,
    input  logic                              finish,
    input  coreTypesPkg::ActiveListIndexPath  finishPtr,
    input  coreTypesPkg::ActiveListIndexPath  queryPtr,
    output logic                              queryDone
);

    logic [coreTypesPkg::ACTIVE_LIST_ENTRY_NUM-1:0] doneBits;
    logic [coreTypesPkg::ACTIVE_LIST_ENTRY_NUM-1:0] doneNext;

    always_comb begin
        doneNext = doneBits;
        if (allocate) begin
            doneNext[allocatePtr] = 1'b0;
        end
        // Finish applied last so it wins a same-entry collision
        if (finish) begin
            doneNext[finishPtr] = 1'b1;
        end
    end

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            doneBits <= '0;
        end else begin
            doneBits <= doneNext;
        end
    end

    assign queryDone = doneBits[queryPtr];

endmodule

// ==== logic/complexIntUnit.sv ====
/*
 * Complex integer unit top level
 * Multiplier pipe, writeback stage, register file and completion table
 */
module complexIntUnit (
    input  logic                              ctrl,
    input  logic                              rstN,
    input  logic                              stall,
    input  logic                              clear,
    input  pipeTypesPkg::ComplexIssueData     issue,
    input  pipeTypesPkg::FlushRange           flushRange,
    input  logic                              alAllocate,
    input  coreTypesPkg::ActiveListIndexPath  alAllocatePtr,
    input  coreTypesPkg::PRegNumPath          regReadNum,
    input  coreTypesPkg::ActiveListIndexPath  alQueryPtr,
    output coreTypesPkg::DataPath             regReadData,
    output logic                              alQueryDone,
    output logic                              wbValid,
    output pipeTypesPkg::OpTag                wbTag
);

    pipeTypesPkg::ComplexResult        execResult;
    logic                              regWe;
    coreTypesPkg::PRegNumPath          regWriteNum;
    coreTypesPkg::DataPath             regWriteData;
    logic                              alWrite;
    coreTypesPkg::ActiveListIndexPath  alWritePtr;

    complexExecStage exec_i (
        .ctrl   (ctrl),
        .rstN   (rstN),
        .stall  (stall),
        .clear  (clear),
        .issue  (issue),
        .result (execResult)
    );

    complexRegWriteStage regWrite_i (
        .ctrl         (ctrl),
        .rstN         (rstN),
        .stall        (stall),
        .clear        (clear),
        .result       (execResult),
        .flushRange   (flushRange),
        .regWe        (regWe),
        .regWriteNum  (regWriteNum),
        .regWriteData (regWriteData),
        .alWrite      (alWrite),
        .alWritePtr   (alWritePtr),
        .wbValid      (wbValid),
        .wbTag        (wbTag)
    );

    physRegFile regFile_i (
        .ctrl      (ctrl),
        .rstN      (rstN),
        .we        (regWe),
        .writeNum  (regWriteNum),
        .writeData (regWriteData),
        .readNum   (regReadNum),
        .readData  (regReadData)
    );

    completionTable complete_i (
        .ctrl        (ctrl),
        .rstN        (rstN),
        .allocate    (alAllocate),
        .allocatePtr (alAllocatePtr),
        .finish      (alWrite),
        .finishPtr   (alWritePtr),
        .queryPtr    (alQueryPtr),
        .queryDone   (alQueryDone)
    );

endmodule

// ==== tests/complexIntUnit_assert.sv ====
/*
 * Writeback assertions for the complex register-write stage
 * Bound into every instance of the writeback stage
 */
module regWriteAssertions (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic regWe,
    input logic wbValid
);

    // No writeback while the backend holds or clears
    property noWbWhenBlocked;
        @(posedge ctrl) disable iff (!rstN) (stall || clear) |-> !wbValid;
    endproperty

    property regWeNeedsWb;
        @(posedge ctrl) disable iff (!rstN) regWe |-> wbValid;
    endproperty

    property quietInReset;
        @(posedge ctrl) !rstN |-> !wbValid;
    endproperty

    blockedCheck: assert property (noWbWhenBlocked)
        else $error("wbValid high while stall or clear is asserted");

    regWeCheck: assert property (regWeNeedsWb)
        else $error("regWe high without wbValid");

    resetCheck: assert property (quietInReset)
        else $error("wbValid high during reset");

endmodule

bind complexRegWriteStage regWriteAssertions regWriteAssert_i (
    .ctrl    (ctrl),
    .rstN    (rstN),
    .stall   (stall),
    .clear   (clear),
    .regWe   (regWe),
    .wbValid (wbValid)
);

// ==== tests/complexIntUnitTb.sv ====
/*
 * Testbench for the complex integer unit
 * Table-driven multiply ops plus flush, stall, clear and reallocation cases
 */
module complexIntUnitTb;

    // One test op with the flush window held over its writeback
    typedef struct packed {
        coreTypesPkg::MulOpCode opCode;
        coreTypesPkg::DataPath srcA;
        coreTypesPkg::DataPath srcB;
        coreTypesPkg::PRegNumPath dst;
        coreTypesPkg::ActiveListIndexPath alPtr;
        logic writeReg;
        pipeTypesPkg::FlushRange flush;
    } TestRow;

    logic ctrl;
    logic rstN;
    logic stall;
    logic clear;
    pipeTypesPkg::ComplexIssueData issue;
    pipeTypesPkg::FlushRange flushRange;
    logic alAllocate;
    coreTypesPkg::ActiveListIndexPath alAllocatePtr;
    coreTypesPkg::PRegNumPath regReadNum;
    coreTypesPkg::ActiveListIndexPath alQueryPtr;
    coreTypesPkg::DataPath regReadData;
    logic alQueryDone;
    logic wbValid;
    pipeTypesPkg::OpTag wbTag;

    TestRow rows[$];
    string rowNames[$];
    coreTypesPkg::DataPath expRegs [coreTypesPkg::PHY_REG_NUM];
    logic [15:0] lfsrState;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;

    complexIntUnit dut_i (
        .ctrl          (ctrl),
        .rstN          (rstN),
        .stall         (stall),
        .clear         (clear),
        .issue         (issue),
        .flushRange    (flushRange),
        .alAllocate    (alAllocate),
        .alAllocatePtr (alAllocatePtr),
        .regReadNum    (regReadNum),
        .alQueryPtr    (alQueryPtr),
        .regReadData   (regReadData),
        .alQueryDone   (alQueryDone),
        .wbValid       (wbValid),
        .wbTag         (wbTag)
    );

    initial begin
        ctrl = 1'b0;
        forever #2 ctrl = ~ctrl;
    end

    // Overall limit on simulated time
    initial begin
        #20000;
        $display("Simulation did not finish within its time limit");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic randWord(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w[i] = lfsrState[0];
        end
    endtask

    // Reference product halves from full 64-bit products
    function automatic logic [31:0] mulRef(input logic [31:0] a, input logic [31:0] b,
                                           input coreTypesPkg::MulOpCode op);
        logic [63:0] uProd;
        logic signed [63:0] sProd;
        uProd = {32'd0, a} * {32'd0, b};
        sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (op)
            coreTypesPkg::mulHighSigned: return sProd[63:32];
            coreTypesPkg::mulHighUnsigned: return uProd[63:32];
            default: return uProd[31:0];
        endcase
    endfunction

    // Walk the window from head to tail
    function automatic bit ptrFlushed(input TestRow r);
        logic [3:0] p;
        if (r.flush.flushAll) return 1'b1;
        if (!r.flush.active) return 1'b0;
        p = r.flush.headPtr;
        while (p != r.flush.tailPtr) begin
            if (p == r.alPtr) return 1'b1;
            p = p + 4'd1;
        end
        return 1'b0;
    endfunction

    function automatic pipeTypesPkg::FlushRange makeFlush(input logic active,
            input logic [3:0] head, input logic [3:0] tail, input logic all);
        pipeTypesPkg::FlushRange f;
        f.active = active;
        f.headPtr = head;
        f.tailPtr = tail;
        f.flushAll = all;
        return f;
    endfunction

    function automatic TestRow makeRow(input coreTypesPkg::MulOpCode op,
            input logic [31:0] a, input logic [31:0] b, input logic [5:0] dst,
            input logic [3:0] ptr, input logic wr, input pipeTypesPkg::FlushRange f);
        TestRow r;
        r.opCode = op;
        r.srcA = a;
        r.srcB = b;
        r.dst = dst;
        r.alPtr = ptr;
        r.writeReg = wr;
        r.flush = f;
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("PASS  %s", name);
        end else begin
            failCount++;
            $display("FAIL  %s", name);
        end
    endtask

    // Issue also allocates the op's active-list entry
    task automatic driveIssue(input TestRow r);
        @(posedge ctrl);
        #1;
        issue.valid = 1'b1;
        issue.opCode = r.opCode;
        issue.srcA = r.srcA;
        issue.srcB = r.srcB;
        issue.tag.writeReg = r.writeReg;
        issue.tag.phyDstRegNum = r.dst;
        issue.tag.activeListPtr = r.alPtr;
        flushRange = '0;
        alAllocate = 1'b1;
        alAllocatePtr = r.alPtr;
    endtask

    task automatic idleIssue();
        @(posedge ctrl);
        #1;
        issue.valid = 1'b0;
        alAllocate = 1'b0;
    endtask

    task automatic waitWb(input int limit, output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge ctrl);
            cycles++;
            if (wbValid) seen = 1'b1;
        end
    endtask

    task automatic checkState(input logic [5:0] dst, input logic [3:0] ptr, input bit expDone);
        @(posedge ctrl);
        #1;
        regReadNum = dst;
        alQueryPtr = ptr;
        @(negedge ctrl);
        checkValue("regReadData", regReadData, expRegs[dst]);
        checkValue("alQueryDone", alQueryDone, expDone);
    endtask

    task automatic runRow(input TestRow r);
        pipeTypesPkg::OpTag expTag;
        bit expWrite;
        bit seen;
        expTag.writeReg = r.writeReg;
        expTag.phyDstRegNum = r.dst;
        expTag.activeListPtr = r.alPtr;
        expWrite = !ptrFlushed(r);
        if (expWrite && r.writeReg) expRegs[r.dst] = mulRef(r.srcA, r.srcB, r.opCode);
        driveIssue(r);
        idleIssue();
        // Window opens once the op sits in the writeback register
        repeat (2) @(posedge ctrl);
        #1;
        flushRange = r.flush;
        waitWb(6, seen);
        if (expWrite && !seen) begin
            $display("No writeback for register %0d within 6 cycles", r.dst);
            errorCount++;
        end else begin
            checkValue("wbValid", seen, expWrite);
        end
        if (seen) checkValue("wbTag", wbTag, expTag);
        checkState(r.dst, r.alPtr, expWrite);
    endtask

    task automatic buildTable();
        logic [31:0] a;
        logic [31:0] b;
        addRow("mulLow small", makeRow(coreTypesPkg::mulLow, 7, 9, 1, 0, 1, '0));
        addRow("mulHighSigned negative",
               makeRow(coreTypesPkg::mulHighSigned, 32'hFFFF_FFFD, 5, 2, 1, 1, '0));
        addRow("mulHighUnsigned large",
               makeRow(coreTypesPkg::mulHighUnsigned, 32'hFFFF_FFFD, 5, 3, 2, 1, '0));
        randWord(a);
        randWord(b);
        addRow("mulLow random", makeRow(coreTypesPkg::mulLow, a, b, 4, 3, 1, '0));
        randWord(a);
        randWord(b);
        addRow("mulHighSigned random", makeRow(coreTypesPkg::mulHighSigned, a, b, 5, 4, 1, '0));
        randWord(a);
        randWord(b);
        addRow("mulHighUnsigned random",
               makeRow(coreTypesPkg::mulHighUnsigned, a, b, 6, 5, 1, '0));
        addRow("no register write", makeRow(coreTypesPkg::mulLow, 3, 3, 1, 6, 0, '0));
        addRow("inside flush range",
               makeRow(coreTypesPkg::mulLow, 11, 13, 7, 7, 1, makeFlush(1, 5, 9, 0)));
        addRow("inside wrapped range",
               makeRow(coreTypesPkg::mulLow, 17, 19, 8, 15, 1, makeFlush(1, 14, 2, 0)));
        addRow("just past wrapped range",
               makeRow(coreTypesPkg::mulLow, 23, 29, 9, 2, 1, makeFlush(1, 14, 2, 0)));
        addRow("flush all",
               makeRow(coreTypesPkg::mulLow, 31, 37, 10, 10, 1, makeFlush(0, 0, 0, 1)));
        addRow("just past range tail",
               makeRow(coreTypesPkg::mulLow, 41, 43, 11, 9, 1, makeFlush(1, 5, 9, 0)));
        addRow("empty range",
               makeRow(coreTypesPkg::mulLow, 47, 53, 12, 11, 1, makeFlush(1, 11, 11, 0)));
    endtask

    task automatic addRow(input string name, input TestRow r);
        rows.push_back(r);
        rowNames.push_back(name);
    endtask

    // Three ops back to back, then four stalled cycles
    task automatic runBurst();
        TestRow ops [3];
        logic [31:0] a;
        logic [31:0] b;
        int got;
        int cycles;
        int errorsBefore;
        bit extra;
        errorsBefore = errorCount;
        for (int k = 0; k < 3; k++) begin
            randWord(a);
            randWord(b);
            ops[k] = makeRow(coreTypesPkg::MulOpCode'(k), a, b, 20 + k, 13 + k, 1, '0);
            expRegs[20 + k] = mulRef(a, b, ops[k].opCode);
            driveIssue(ops[k]);
        end
        @(posedge ctrl);
        #1;
        issue.valid = 1'b0;
        alAllocate = 1'b0;
        stall = 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(negedge ctrl);
            if (wbValid) begin
                $display("Writeback seen while the backend was stalled");
                errorCount++;
            end
        end
        @(posedge ctrl);
        #1;
        stall = 1'b0;
        got = 0;
        cycles = 0;
        while (got < 3 && cycles < 12) begin
            @(negedge ctrl);
            cycles++;
            if (wbValid) begin
                checkValue("wbTag.phyDstRegNum", wbTag.phyDstRegNum, ops[got].dst);
                got++;
            end
        end
        if (got < 3) begin
            $display("Only %0d of 3 burst writebacks arrived before the timeout", got);
            errorCount++;
        end
        waitWb(4, extra);
        if (extra) begin
            $display("An extra writeback followed the three burst ops");
            errorCount++;
        end
        for (int k = 0; k < 3; k++) checkState(ops[k].dst, ops[k].alPtr, 1'b1);
        reportTest("back-to-back with stall", errorsBefore);
    endtask

    // Ops in flight are dropped by clear, a later op still completes
    task automatic runClear();
        TestRow r;
        logic [31:0] a;
        logic [31:0] b;
        int errorsBefore;
        bit seen;
        errorsBefore = errorCount;
        for (int k = 0; k < 3; k++) begin
            randWord(a);
            randWord(b);
            driveIssue(makeRow(coreTypesPkg::mulHighUnsigned, a, b, 30 + k, k, 1, '0));
        end
        @(posedge ctrl);
        #1;
        issue.valid = 1'b0;
        alAllocate = 1'b0;
        clear = 1'b1;
        @(posedge ctrl);
        #1;
        clear = 1'b0;
        waitWb(6, seen);
        checkValue("wbValid", seen, 1'b0);
        for (int k = 0; k < 3; k++) checkState(30 + k, k, 1'b0);
        randWord(a);
        randWord(b);
        r = makeRow(coreTypesPkg::mulLow, a, b, 33, 3, 1, '0);
        runRow(r);
        reportTest("clear with ops in flight", errorsBefore);
    endtask

    task automatic runRealloc();
        int errorsBefore;
        errorsBefore = errorCount;
        checkState(5, 4, 1'b1);
        @(posedge ctrl);
        #1;
        alAllocate = 1'b1;
        alAllocatePtr = 4'd4;
        @(posedge ctrl);
        #1;
        alAllocate = 1'b0;
        checkState(5, 4, 1'b0);
        runRow(makeRow(coreTypesPkg::mulLow, 32'h1234_5678, 32'h9, 5, 4, 1, '0));
        reportTest("reallocation clears done", errorsBefore);
    endtask

    initial begin
        int errorsBefore;
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        issue = '0;
        flushRange = '0;
        alAllocate = 1'b0;
        alAllocatePtr = '0;
        regReadNum = '0;
        alQueryPtr = '0;
        lfsrState = 16'd50;
        for (int i = 0; i < coreTypesPkg::PHY_REG_NUM; i++) expRegs[i] = '0;
        buildTable();
        repeat (4) @(posedge ctrl);
        #1;
        rstN = 1'b1;

        errorsBefore = errorCount;
        checkValue("wbValid", wbValid, 1'b0);
        checkState(0, 0, 1'b0);
        reportTest("reset state", errorsBefore);

        foreach (rows[i]) begin
            errorsBefore = errorCount;
            runRow(rows[i]);
            reportTest(rowNames[i], errorsBefore);
        end
        runBurst();
        runClear();
        runRealloc();

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/coreTypesPkg.sv
logic/pipeTypesPkg.sv
logic/complexExecStage.sv
logic/complexRegWriteStage.sv
logic/physRegFile.sv
logic/completionTable.sv
logic/complexIntUnit.sv
tests/complexIntUnit_assert.sv
tests/complexIntUnitTb.sv
